// ==== flist.f ====
hdl/rv_pkg.sv
hdl/core_if.sv
hdl/inst_decode.sv
hdl/alu.sv
hdl/regfile.sv
hdl/core_top.sv
bench/core_assert.sv
bench/core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile the core and its testbench with Verilator, run, and check for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module core_tb -f flist.f -o core_sim

out=$(./obj_dir/core_sim || true)
echo "$out"

if echo "$out" | grep -qx "test passed"; then
	exit 0
else
	exit 1
fi

// ==== bench/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_tb
	import rv_pkg::*;
();

	localparam int MAX_CYCLES = 2000; // about 600 instructions plus reset and drains.

	typedef struct packed {
		logic      illegal;
		reg_addr_t rd;
		xword_t    data;
	} expect_t;

	logic        clk = 1'b0;
	logic        rst = 1'b1;
	logic        inst_valid = 1'b0;
	logic [31:0] inst = '0;
	logic        retire_valid;
	logic        retire_illegal;
	reg_addr_t   retire_rd;
	xword_t      retire_data;

	xword_t      ref_regs [NUM_REGS];
	expect_t     exp_q [$];
	logic        due_now = 1'b0;
	logic        due_next = 1'b0;
	int          cycles = 0;
	int          errors = 0;
	int          retires = 0;
	int          tests = 0;
	int          tests_failed = 0;
	int          mark_errors = 0;
	int          mark_retires = 0;
	int unsigned seed_val;

	core_top u_core_top (
		.clk            (clk),
		.rst            (rst),
		.inst_valid     (inst_valid),
		.inst           (inst),
		.retire_valid   (retire_valid),
		.retire_illegal (retire_illegal),
		.retire_rd      (retire_rd),
		.retire_data    (retire_data)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("test failed");
			$finish;
		end
	end

	function automatic logic [31:0] rtype(input logic [6:0] f7, input reg_addr_t rs2,
			input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd,
			input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] itype(input logic [11:0] imm, input reg_addr_t rs1,
			input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	// expected retire straight from the rv64i rules.
	function automatic expect_t ref_exec(input logic [31:0] w, input xword_t a, input xword_t b);
		expect_t     e;
		logic [2:0]  f3;
		logic [6:0]  f7;
		xword_t      imm;
		xword_t      r;
		logic [31:0] r32;
		logic        bad;
		f3  = w[14:12];
		f7  = w[31:25];
		imm = {{52{w[31]}}, w[31:20]};
		r   = '0;
		r32 = '0;
		bad = 1'b0;
		case (w[6:0])
			OPC_OP: begin
				case ({f7, f3})
					{F7_BASE, 3'd0}: r = a + b;
					{F7_ALT, 3'd0}:  r = a - b;
					{F7_BASE, 3'd1}: r = a << b[5:0];
					{F7_BASE, 3'd2}: r = {63'b0, $signed(a) < $signed(b)};
					{F7_BASE, 3'd3}: r = {63'b0, a < b};
					{F7_BASE, 3'd4}: r = a ^ b;
					{F7_BASE, 3'd5}: r = a >> b[5:0];
					{F7_ALT, 3'd5}:  r = $signed(a) >>> b[5:0];
					{F7_BASE, 3'd6}: r = a | b;
					{F7_BASE, 3'd7}: r = a & b;
					default:         bad = 1'b1;
				endcase
			end
			OPC_OP_IMM: begin
				case (f3)
					3'd0: r = a + imm;
					3'd1: begin
						r   = a << w[25:20];
						bad = (w[31:26] != 6'b000000);
					end
					3'd2: r = {63'b0, $signed(a) < $signed(imm)};
					3'd3: r = {63'b0, a < imm};
					3'd4: r = a ^ imm;
					3'd5: begin
						if (w[30]) begin
							r = $signed(a) >>> w[25:20];
						end else begin
							r = a >> w[25:20];
						end
						bad = (w[31:26] != 6'b000000) && (w[31:26] != 6'b010000);
					end
					3'd6: r = a | imm;
					default: r = a & imm;
				endcase
			end
			OPC_OP_32: begin
				case ({f7, f3})
					{F7_BASE, 3'd0}: r32 = a[31:0] + b[31:0];
					{F7_ALT, 3'd0}:  r32 = a[31:0] - b[31:0];
					{F7_BASE, 3'd1}: r32 = a[31:0] << b[4:0];
					{F7_BASE, 3'd5}: r32 = a[31:0] >> b[4:0];
					{F7_ALT, 3'd5}:  r32 = $signed(a[31:0]) >>> b[4:0];
					default:         bad = 1'b1;
				endcase
				r = {{32{r32[31]}}, r32};
			end
			OPC_OP_IMM_32: begin
				case ({f7, f3})
					{F7_BASE, 3'd1}: r32 = a[31:0] << w[24:20];
					{F7_BASE, 3'd5}: r32 = a[31:0] >> w[24:20];
					{F7_ALT, 3'd5}:  r32 = $signed(a[31:0]) >>> w[24:20];
					default: begin
						r32 = a[31:0] + imm[31:0];
						bad = (f3 != 3'd0); // addiw takes any immediate.
					end
				endcase
				r = {{32{r32[31]}}, r32};
			end
			OPC_LUI: r = {{32{w[31]}}, w[31:12], 12'b0};
			default: bad = 1'b1;
		endcase
		e.illegal = bad;
		e.rd      = w[11:7];
		e.data    = (bad || w[11:7] == 5'd0) ? '0 : r;
		return e;
	endfunction

	task automatic issue(input logic [31:0] w);
		expect_t e;
		@(posedge clk);
		e = ref_exec(w, ref_regs[w[19:15]], ref_regs[w[24:20]]);
		if (!e.illegal && e.rd != 5'd0) begin
			ref_regs[e.rd] = e.data;
		end
		exp_q.push_back(e);
		inst_valid <= 1'b1;
		inst       <= w;
	endtask

	task automatic end_test(input string name);
		@(posedge clk);
		inst_valid <= 1'b0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		tests++;
		if (errors != mark_errors) begin
			tests_failed++;
		end
		$display("%-14s %0d retires, %0d errors", name, retires - mark_retires,
			errors - mark_errors);
		mark_errors  = errors;
		mark_retires = retires;
	endtask

	task automatic random_run(input int n);
		logic [31:0] w;
		logic [31:0] pick;
		for (int i = 0; i < n; i++) begin
			w    = $urandom;
			pick = $urandom;
			case (pick[2:0])
				3'd0, 3'd1: w[6:0] = OPC_OP;
				3'd2, 3'd3: w[6:0] = OPC_OP_IMM;
				3'd4:       w[6:0] = OPC_OP_32;
				3'd5:       w[6:0] = OPC_OP_IMM_32;
				3'd6:       w[6:0] = OPC_LUI;
				default:    w[6:0] = w[6:0]; // raw opcode, mostly unknown.
			endcase
			// bias funct7 and shift upper bits toward legal values.
			if (pick[5:3] != 3'd0) begin
				if (w[6:0] == OPC_OP || w[6:0] == OPC_OP_32) begin
					w[31:25] = pick[6] ? F7_ALT : F7_BASE;
				end else if ((w[6:0] == OPC_OP_IMM || w[6:0] == OPC_OP_IMM_32) &&
						w[13:12] == 2'b01) begin
					w[31:26] = pick[6] ? F7_ALT[6:1] : F7_BASE[6:1];
				end
			end
			issue(w);
		end
	endtask

	always @(posedge clk) begin
		expect_t e;
		due_now  = due_next;
		due_next = inst_valid;
		if (retire_valid) begin
			assert (due_now && exp_q.size() != 0) else begin
				$display("at %0t: a retire came with no instruction issued for it", $time);
				errors++;
			end
			if (exp_q.size() != 0) begin
				e = exp_q.pop_front();
				retires++;
				assert (retire_illegal === e.illegal) else begin
					$display("** Error at %0t: retire_illegal expected %0b, got %0b",
						$time, e.illegal, retire_illegal);
					errors++;
				end
				assert (retire_rd === e.rd) else begin
					$display("** Error at %0t: retire_rd expected %0d, got %0d",
						$time, e.rd, retire_rd);
					errors++;
				end
				assert (retire_data === e.data) else begin
					$display("** Error at %0t: retire_data expected %h, got %h",
						$time, e.data, retire_data);
					errors++;
				end
			end
		end else begin
			assert (!due_now) else begin
				$display("at %0t: an issued instruction never retired", $time);
				errors++;
				if (exp_q.size() != 0) begin
					void'(exp_q.pop_front());
				end
			end
		end
	end

	initial begin
		seed_val = $urandom(32'hb2db);
		for (int i = 0; i < NUM_REGS; i++) begin
			ref_regs[i] = '0;
		end
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		issue(rtype(F7_BASE, 3, 2, F3_ADD_SUB, 1, OPC_OP));
		for (int i = 0; i < NUM_REGS; i++) begin
			issue(rtype(F7_BASE, 0, reg_addr_t'(i), F3_OR, reg_addr_t'(i), OPC_OP));
		end
		end_test("reset_reads");

		issue(itype(12'h005, 0, F3_ADD_SUB, 0, OPC_OP_IMM));
		issue(rtype(F7_BASE, 0, 0, F3_OR, 5, OPC_OP));
		end_test("x0_writes");

		issue(itype(12'hfff, 0, F3_ADD_SUB, 1, OPC_OP_IMM)); // -1.
		issue(itype(12'h800, 0, F3_ADD_SUB, 2, OPC_OP_IMM)); // -2048.
		issue(itype(12'h005, 0, F3_ADD_SUB, 3, OPC_OP_IMM));
		issue({20'h80000, 5'd4, OPC_LUI});
		issue(rtype(F7_BASE, 3, 1, F3_SLT, 5, OPC_OP));
		issue(rtype(F7_BASE, 3, 1, F3_SLTU, 6, OPC_OP));
		issue(itype(12'hfff, 3, F3_SLT, 7, OPC_OP_IMM));
		issue(itype(12'hfff, 3, F3_SLTU, 8, OPC_OP_IMM));
		issue(rtype(F7_ALT, 3, 4, F3_SRL_SRA, 9, OPC_OP));
		issue(rtype(F7_BASE, 3, 4, F3_SRL_SRA, 10, OPC_OP));
		issue(itype(12'h43f, 4, F3_SRL_SRA, 11, OPC_OP_IMM)); // srai by 63.
		issue(itype(12'h03f, 4, F3_SRL_SRA, 12, OPC_OP_IMM));
		issue(itype(12'h03f, 3, F3_SLL, 13, OPC_OP_IMM));
		issue(itype(12'h03f, 0, F3_ADD_SUB, 14, OPC_OP_IMM));
		issue(rtype(F7_BASE, 14, 3, F3_SLL, 15, OPC_OP));
		issue(rtype(F7_ALT, 14, 4, F3_SRL_SRA, 16, OPC_OP));
		issue(itype(12'h555, 1, F3_XOR, 17, OPC_OP_IMM));
		issue(itype(12'h8f0, 3, F3_OR, 18, OPC_OP_IMM));
		issue(itype(12'hff0, 1, F3_AND, 19, OPC_OP_IMM));
		issue(rtype(F7_ALT, 1, 3, F3_ADD_SUB, 20, OPC_OP));
		issue(rtype(F7_BASE, 2, 1, F3_XOR, 21, OPC_OP));
		issue(rtype(F7_BASE, 2, 3, F3_OR, 22, OPC_OP));
		issue(rtype(F7_BASE, 2, 1, F3_AND, 23, OPC_OP));
		issue(rtype(F7_BASE, 1, 2, F3_ADD_SUB, 24, OPC_OP));
		end_test("op_and_imm");

		issue({20'h7ffff, 5'd25, OPC_LUI});
		issue(itype(12'h7ff, 25, F3_ADD_SUB, 25, OPC_OP_IMM)); // 0x7ffff7ff.
		issue(rtype(F7_BASE, 25, 25, F3_ADD_SUB, 26, OPC_OP_32)); // addw overflows.
		issue(itype(12'h7ff, 25, F3_ADD_SUB, 27, OPC_OP_IMM_32));
		issue(rtype(F7_ALT, 25, 0, F3_ADD_SUB, 28, OPC_OP_32));
		issue(rtype(F7_ALT, 3, 4, F3_SRL_SRA, 29, OPC_OP_32)); // negative low word.
		issue(rtype(F7_BASE, 3, 4, F3_SRL_SRA, 30, OPC_OP_32));
		issue(itype(12'h01f, 3, F3_SLL, 31, OPC_OP_IMM_32)); // slliw by 31.
		issue(rtype(F7_BASE, 3, 25, F3_SLL, 5, OPC_OP_32));
		issue(itype(12'h41f, 4, F3_SRL_SRA, 6, OPC_OP_IMM_32));
		issue(itype(12'h004, 4, F3_SRL_SRA, 7, OPC_OP_IMM_32));
		issue({20'hfffff, 5'd8, OPC_LUI});
		end_test("word_and_lui");

		for (int i = 1; i < NUM_REGS - 1; i++) begin
			if (i % 3 == 0) begin
				issue(rtype(F7_BASE, reg_addr_t'(i), reg_addr_t'(i), F3_ADD_SUB,
					reg_addr_t'(i + 1), OPC_OP));
			end else if (i % 3 == 1) begin
				issue(itype(12'(i * 37), reg_addr_t'(i), F3_ADD_SUB, reg_addr_t'(i + 1),
					OPC_OP_IMM));
			end else begin
				issue(itype(12'ha5a, reg_addr_t'(i), F3_XOR, reg_addr_t'(i + 1), OPC_OP_IMM));
			end
		end
		end_test("back_to_back");

		issue({20'h12345, 5'd9, 7'b1111111}); // no such opcode.
		issue(rtype(7'b0000001, 3, 1, F3_ADD_SUB, 10, OPC_OP));
		issue(rtype(F7_ALT, 3, 1, F3_XOR, 11, OPC_OP));
		issue(itype(12'h025, 3, F3_SLL, 12, OPC_OP_IMM_32)); // shamt bit 5 set.
		issue(itype(12'h425, 4, F3_SRL_SRA, 13, OPC_OP_IMM_32));
		issue(rtype(F7_BASE, 3, 1, F3_SLT, 14, OPC_OP_32));
		for (int i = 9; i < 15; i++) begin
			issue(rtype(F7_BASE, 0, reg_addr_t'(i), F3_OR, reg_addr_t'(i), OPC_OP));
		end
		end_test("illegal");

		random_run(500);
		end_test("random");

		errors = errors + int'(u_core_top.u_regfile.u_core_assert.fail_count);
		$display("summary: %0d tests, %0d failed, %0d retires checked, %0d errors",
			tests, tests_failed, retires, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/core_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_assert
	import rv_pkg::*;
(
	input logic      clk,
	input logic      rst,
	input logic      strobe,
	input logic      retire_valid,
	input logic      retire_illegal,
	input xword_t    retire_data,
	input reg_addr_t rs1_addr,
	input xword_t    rs1_data,
	input reg_addr_t rs2_addr,
	input xword_t    rs2_data
);

	int unsigned fail_count = 0;

	a_quiet: assert property (@(posedge clk) disable iff (rst) !strobe |=> !retire_valid)
		else begin
			$error("retire_valid high after a cycle without write strobe");
			fail_count++;
		end

	// illegal words never write, so their commit record carries no data.
	a_illegal_zero: assert property (@(posedge clk) disable iff (rst)
			retire_valid && retire_illegal |-> retire_data == '0)
		else begin
			$error("illegal retire carries nonzero data");
			fail_count++;
		end

	a_x0_rs1: assert property (@(posedge clk) disable iff (rst) rs1_addr == '0 |-> rs1_data == '0)
		else begin
			$error("x0 read through rs1 is not zero");
			fail_count++;
		end

	a_x0_rs2: assert property (@(posedge clk) disable iff (rst) rs2_addr == '0 |-> rs2_data == '0)
		else begin
			$error("x0 read through rs2 is not zero");
			fail_count++;
		end

endmodule

bind regfile core_assert u_core_assert (
	.clk            (clk),
	.rst            (rst),
	.strobe         (wb.valid),
	.retire_valid   (retire_valid),
	.retire_illegal (retire_illegal),
	.retire_data    (retire_data),
	.rs1_addr       (rs1_addr),
	.rs1_data       (rs1_data),
	.rs2_addr       (rs2_addr),
	.rs2_data       (rs2_data)
);

`default_nettype wire

// ==== hdl/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_top
	import rv_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        inst_valid,
	input  logic [31:0] inst,
	output logic        retire_valid,
	output logic        retire_illegal,
	output reg_addr_t   retire_rd,
	output xword_t      retire_data
);

	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	xword_t    rs1_data;
	xword_t    rs2_data;

	exe_bus_if u_exe_bus ();
	wb_if      u_wb ();

	inst_decode u_inst_decode (
		.inst_valid (inst_valid),
		.inst       (inst),
		.rs1_addr   (rs1_addr),
		.rs2_addr   (rs2_addr),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.exe        (u_exe_bus.decode)
	);

	alu u_alu (
		.exe (u_exe_bus.exec),
		.wb  (u_wb.exec)
	);

	regfile u_regfile (
		.clk            (clk),
		.rst            (rst),
		.rs1_addr       (rs1_addr),
		.rs2_addr       (rs2_addr),
		.rs1_data       (rs1_data),
		.rs2_data       (rs2_data),
		.wb             (u_wb.rf),
		.retire_valid   (retire_valid),
		.retire_illegal (retire_illegal),
		.retire_rd      (retire_rd),
		.retire_data    (retire_data)
	);

endmodule

`default_nettype wire

// ==== hdl/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile
	import rv_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  reg_addr_t rs1_addr,
	input  reg_addr_t rs2_addr,
	output xword_t    rs1_data,
	output xword_t    rs2_data,
	wb_if.rf          wb,
	output logic      retire_valid,
	output logic      retire_illegal,
	output reg_addr_t retire_rd,
	output xword_t    retire_data
);

	xword_t regs [NUM_REGS];
	logic   wr_en;

	assign wr_en = wb.valid && wb.wen && (wb.rd != '0); // x0 is never written.

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wb.rd] <= wb.data;
		end
	end

	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

	// commit record, one cycle after the strobe.
	always_ff @(posedge clk) begin
		if (rst) begin
			retire_valid   <= 1'b0;
			retire_illegal <= 1'b0;
			retire_rd      <= '0;
			retire_data    <= '0;
		end else begin
			retire_valid <= wb.valid;
			if (wb.valid) begin
				retire_illegal <= wb.illegal;
				retire_rd      <= wb.rd;
				retire_data    <= wr_en ? wb.data : '0; // zero for x0 or illegal.
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
	import rv_pkg::*;
(
	exe_bus_if.exec exe,
	wb_if.exec      wb
);

	logic [5:0]  shamt;
	logic [31:0] a_lo;
	xword_t      a_shift;
	xword_t      a_sext;
	xword_t      res;
	xword_t      result;

	assign shamt = exe.word ? {1'b0, exe.src_b[4:0]} : exe.src_b[5:0];
	assign a_lo  = exe.src_a[31:0];

	// word right shifts work on the low half only.
	assign a_shift = exe.word ? {32'b0, a_lo} : exe.src_a;
	assign a_sext  = exe.word ? {{32{a_lo[31]}}, a_lo} : exe.src_a;

	always_comb begin
		case (exe.op)
			ALU_ADD: begin
				res = exe.src_a + exe.src_b;
			end
			ALU_SUB: begin
				res = exe.src_a - exe.src_b;
			end
			ALU_SLL: begin
				res = exe.src_a << shamt;
			end
			ALU_SLT: begin
				res = {63'b0, $signed(exe.src_a) < $signed(exe.src_b)};
			end
			ALU_SLTU: begin
				res = {63'b0, exe.src_a < exe.src_b};
			end
			ALU_XOR: begin
				res = exe.src_a ^ exe.src_b;
			end
			ALU_SRL: begin
				res = a_shift >> shamt;
			end
			ALU_SRA: begin
				res = $signed(a_sext) >>> shamt;
			end
			ALU_OR: begin
				res = exe.src_a | exe.src_b;
			end
			ALU_AND: begin
				res = exe.src_a & exe.src_b;
			end
			ALU_PASS_B: begin
				res = exe.src_b; // lui.
			end
			default: begin
				res = '0;
			end
		endcase
	end

	assign result = exe.word ? {{32{res[31]}}, res[31:0]} : res;

	assign wb.valid   = exe.valid;
	assign wb.illegal = exe.illegal;
	assign wb.rd      = exe.rd;
	assign wb.data    = result;
	assign wb.wen     = exe.wen;

endmodule

`default_nettype wire

// ==== hdl/inst_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decode
	import rv_pkg::*;
(
	input  logic            inst_valid,
	input  logic [31:0]     inst,
	output reg_addr_t       rs1_addr,
	output reg_addr_t       rs2_addr,
	input  xword_t          rs1_data,
	input  xword_t          rs2_data,
	exe_bus_if.decode       exe
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [5:0] funct6; // rv64 immediate shifts use a 6-bit shamt.
	reg_addr_t  rd;
	xword_t     imm_i;
	xword_t     imm_u;

	xword_t     imm;
	logic       use_imm;
	logic       legal;
	logic       word;
	alu_op_t    op;

	assign opcode   = inst[6:0];
	assign rd       = inst[11:7];
	assign funct3   = inst[14:12];
	assign rs1_addr = inst[19:15];
	assign rs2_addr = inst[24:20];
	assign funct7   = inst[31:25];
	assign funct6   = inst[31:26];

	assign imm_i = {{52{inst[31]}}, inst[31:20]};
	assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};

	always_comb begin
		op      = ALU_ADD;
		word    = 1'b0;
		use_imm = 1'b0;
		imm     = imm_i;
		legal   = 1'b1;
		case (opcode)
			OPC_OP, OPC_OP_32: begin
				word = (opcode == OPC_OP_32);
				case (funct3)
					F3_ADD_SUB: begin
						op    = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
						legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
					end
					F3_SLL: begin
						op    = ALU_SLL;
						legal = (funct7 == F7_BASE);
					end
					F3_SRL_SRA: begin
						op    = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
						legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
					end
					F3_SLT: begin
						op    = ALU_SLT;
						legal = (funct7 == F7_BASE) && !word;
					end
					F3_SLTU: begin
						op    = ALU_SLTU;
						legal = (funct7 == F7_BASE) && !word;
					end
					F3_XOR: begin
						op    = ALU_XOR;
						legal = (funct7 == F7_BASE) && !word;
					end
					F3_OR: begin
						op    = ALU_OR;
						legal = (funct7 == F7_BASE) && !word;
					end
					default: begin
						op    = ALU_AND;
						legal = (funct7 == F7_BASE) && !word;
					end
				endcase
			end
			OPC_OP_IMM, OPC_OP_IMM_32: begin
				word    = (opcode == OPC_OP_IMM_32);
				use_imm = 1'b1;
				case (funct3)
					F3_ADD_SUB: op = ALU_ADD;
					F3_SLL: begin
						op = ALU_SLL;
						// a word shift with shamt[5] set fails the funct7 check.
						legal = word ? (funct7 == F7_BASE) : (funct6 == F7_BASE[6:1]);
					end
					F3_SRL_SRA: begin
						op = inst[30] ? ALU_SRA : ALU_SRL;
						if (word) begin
							legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
						end else begin
							legal = (funct6 == F7_BASE[6:1]) || (funct6 == F7_ALT[6:1]);
						end
					end
					F3_SLT: begin
						op    = ALU_SLT;
						legal = !word;
					end
					F3_SLTU: begin
						op    = ALU_SLTU;
						legal = !word;
					end
					F3_XOR: begin
						op    = ALU_XOR;
						legal = !word;
					end
					F3_OR: begin
						op    = ALU_OR;
						legal = !word;
					end
					default: begin
						op    = ALU_AND;
						legal = !word;
					end
				endcase
			end
			OPC_LUI: begin
				op      = ALU_PASS_B;
				use_imm = 1'b1;
				imm     = imm_u;
			end
			default: legal = 1'b0;
		endcase
	end

	assign exe.valid   = inst_valid;
	assign exe.illegal = !legal;
	assign exe.op      = op;
	assign exe.word    = word;
	assign exe.src_a   = rs1_data;
	assign exe.src_b   = use_imm ? imm : rs2_data;
	assign exe.rd      = rd;
	assign exe.wen     = legal; // every supported instruction writes rd.

endmodule

`default_nettype wire

// ==== hdl/core_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface exe_bus_if
	import rv_pkg::*;
();
	logic    valid;
	logic    illegal;
	alu_op_t op;
	logic    word;
	xword_t  src_a;
	xword_t  src_b; // rs2 data or immediate.
	reg_addr_t rd;
	logic    wen;

	modport decode (output valid, illegal, op, word, src_a, src_b, rd, wen);
	modport exec (input valid, illegal, op, word, src_a, src_b, rd, wen);
endinterface

interface wb_if
	import rv_pkg::*;
();
	logic      valid;
	logic      illegal;
	reg_addr_t rd;
	xword_t    data;
	logic      wen;

	modport exec (output valid, illegal, rd, data, wen);
	modport rf (input valid, illegal, rd, data, wen);
endinterface

`default_nettype wire

// ==== hdl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

	localparam int XLEN       = 64;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;

	typedef logic [XLEN-1:0]       xword_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// major opcodes, inst[6:0]
	localparam logic [6:0] OPC_OP        = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
	localparam logic [6:0] OPC_OP_32     = 7'b0111011;
	localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
	localparam logic [6:0] OPC_LUI       = 7'b0110111;

	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000; // sub and arithmetic shifts.

	// operation only; the 32-bit form is carried separately as word.
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_t;

endpackage

`default_nettype wire
